// File: include/fpm_config.svh
/*
	FPM exponent unit constants
	datapath widths, alignment limit and per-operation step counts
*/

`ifndef FPM_CONFIG_SVH
`define FPM_CONFIG_SVH

`define FPM_EXP_WIDTH 8
`define FPM_FIC_WIDTH 6

// exponent difference that shifts the whole mantissa out
`define FPM_ALIGN_LIMIT 40

// step counts loaded by the preparation step
`define FPM_FIC_MF 39
`define FPM_FIC_DF 40
`define FPM_FIC_MW 16
`define FPM_FIC_DW 17

`endif

// File: rtl/fpm_pkg.sv
/*
	FPM exponent unit shared types
	opcode, exponent, micro-step control, decoded operation and indicator
	flag types used across the exponent and sequencing datapath
*/

`include "fpm_config.svh"

package fpm_pkg;

	// arithmetic opcode field
	typedef logic [2:0] fp_opcode_t;

	// D register value, two guard bits over the exponent
	typedef logic signed [`FPM_EXP_WIDTH+1:0] exp_t;

	// one line per operation, opcode 0 at the top
	typedef struct packed {
		logic ad;
		logic sd;
		logic mw;
		logic dw;
		logic af;
		logic sf;
		logic mf;
		logic df;
	} fp_ops_t;

	typedef struct packed {
		logic ff;	// any floating operation
		logic ss;	// any fixed operation
		logic puf;	// any arithmetic unit operation
	} fp_class_t;

	// micro-step strobes, each a single-cycle pulse
	typedef struct packed {
		logic ld_d;
		logic lkb;
		logic ld_b;
		logic fcb;
		logic scc;
		logic pc8;
		logic prep;
		logic align;
		logic step;
		logic exp_chk;
		fp_opcode_t opcode;
	} fpm_ctrl_t;

	typedef struct packed {
		logic g;
		logic wdt;
		logic wt;
		logic fi1;
		logic fi2;
	} fpm_flags_t;

endpackage

// File: rtl/fpm_op_decoder.sv
/*
	FPM instruction decoder
	one-hot decode of the arithmetic opcode into eight operation lines,
	plus the floating, fixed and arithmetic-unit class lines
*/

`timescale 1ns/10ps

module fpm_op_decoder (
	input  fpm_pkg::fp_opcode_t opcode,
	input  logic                pufa,
	input  logic                nrf,
	output fpm_pkg::fp_ops_t    ops,
	output fpm_pkg::fp_class_t  op_class
);

	logic [7:0] sel;

	// opcode 0 lands on the top bit (ad)
	always_comb begin
		sel = 8'b1000_0000 >> opcode;
	end

	// decoder is enabled only by an arithmetic unit instruction
	always_comb begin
		if (pufa) begin
			ops = sel;
		end else begin
			ops = '0;
		end
	end

	// top opcode bit marks the floating operations
	always_comb begin
		op_class.ff  = nrf | opcode[2];
		op_class.ss  = pufa & ~opcode[2];
		op_class.puf = pufa | nrf;
	end

endmodule

// File: rtl/fpm_exp_adder.sv
/*
	FPM exponent adder
	D and B registers, four-mode B bus, 10-bit exponent adder,
	L bus into D and the |sum| >= alignment limit detector
*/

`timescale 1ns/10ps

`include "fpm_config.svh"

module fpm_exp_adder (
	input  logic                       wdtwtg_clk,
	input  logic                       _0_f,
	input  fpm_pkg::fpm_ctrl_t         ctrl,
	input  logic [`FPM_EXP_WIDTH-1:0]  w,
	output fpm_pkg::exp_t              d,
	output fpm_pkg::exp_t              sum,
	output logic                       over_limit
);

	import fpm_pkg::*;

	localparam int sign_bit = `FPM_EXP_WIDTH + 1;

	logic [`FPM_EXP_WIDTH-1:0] b;
	logic [`FPM_EXP_WIDTH-1:0] b_bus;
	exp_t                      l_bus;
	logic [sign_bit+1:0]       sum_mag;

	// D register, loaded from the L bus
	always_ff @(posedge wdtwtg_clk or posedge _0_f) begin
		if (_0_f) begin
			d <= '0;
		end else if (ctrl.ld_d) begin
			d <= l_bus;
		end
	end

	// B takes the exponent part of D, guard bits dropped
	always_ff @(posedge wdtwtg_clk or posedge _0_f) begin
		if (_0_f) begin
			b <= '0;
		end else if (ctrl.ld_b) begin
			b <= d[`FPM_EXP_WIDTH-1:0];
		end
	end

	// B bus mode
	always_comb begin
		case ({ctrl.fcb, ctrl.scc})
			2'b00: b_bus = ~b;
			2'b01: b_bus = b;
			2'b10: b_bus = '1;
			default: b_bus = '0;
		endcase
	end

	// B bus sign-extended into the guard bits, wraps in ten bits
	always_comb begin
		sum = d + {{2{b_bus[`FPM_EXP_WIDTH-1]}}, b_bus} + ctrl.pc8;
	end

	// W byte sign-extended, or adder loopback
	always_comb begin
		if (ctrl.lkb) begin
			l_bus = {{2{w[`FPM_EXP_WIDTH-1]}}, w};
		end else begin
			l_bus = sum;
		end
	end

	// magnitude needs one extra bit for the most negative sum
	always_comb begin
		if (sum[sign_bit]) begin
			sum_mag = -{sum[sign_bit], sum};
		end else begin
			sum_mag = {1'b0, sum};
		end
		over_limit = (sum_mag >= `FPM_ALIGN_LIMIT);
	end

endmodule

// File: rtl/fpm_step_counter.sv
/*
	FPM shift-step counter
	loadable up/down counter with synchronous clear and a zero output
*/

`timescale 1ns/10ps

`include "fpm_config.svh"

module fpm_step_counter #(
	parameter int width = `FPM_FIC_WIDTH
) (
	input  logic             wdtwtg_clk,
	input  logic             _0_f,
	input  logic             clear,
	input  logic             load,
	input  logic [width-1:0] load_value,
	input  logic             step,
	input  logic             up,
	output logic             zero
);

	logic [width-1:0] cnt;

	// clear wins over load, load wins over step
	always_ff @(posedge wdtwtg_clk or posedge _0_f) begin
		if (_0_f) begin
			cnt <= '0;
		end else if (clear) begin
			cnt <= '0;
		end else if (load) begin
			cnt <= load_value;
		end else if (step) begin
			// wraps modulo 2**width
			if (up) begin
				cnt <= cnt + 1'b1;
			end else begin
				cnt <= cnt - 1'b1;
			end
		end
	end

	always_comb begin
		zero = (cnt == '0);
	end

endmodule

// File: rtl/fpm_indicators.sv
/*
	FPM alignment indicators and exponent interrupts
	g, wdt and wt captured on the alignment step, step counter load
	selection, and single-cycle exponent overflow/underflow pulses
*/

`timescale 1ns/10ps

`include "fpm_config.svh"

module fpm_indicators (
	input  logic                      wdtwtg_clk,
	input  logic                      _0_f,
	input  fpm_pkg::fpm_ctrl_t        ctrl,
	input  fpm_pkg::fp_ops_t          ops,
	input  fpm_pkg::fp_class_t        op_class,
	input  fpm_pkg::exp_t             d,
	input  fpm_pkg::exp_t             sum,
	input  logic                      over_limit,
	output fpm_pkg::fpm_flags_t       flags,
	output logic                      cnt_clear,
	output logic                      cnt_load,
	output logic [`FPM_FIC_WIDTH-1:0] cnt_value,
	output logic                      cnt_step,
	output logic                      cnt_up
);

	localparam int sign_bit = `FPM_EXP_WIDTH + 1;

	logic align_en;
	logic prep_en;
	logic chk_en;

	// alignment only matters for floating add and subtract
	always_comb begin
		align_en = ctrl.align & (ops.af | ops.sf);
		prep_en  = ctrl.prep & (ops.mf | ops.df | ops.mw | ops.dw);
		chk_en   = ctrl.exp_chk & op_class.ff;
	end

	// indicators and interrupt pulses
	always_ff @(posedge wdtwtg_clk or posedge _0_f) begin
		if (_0_f) begin
			flags <= '0;
		end else begin
			if (align_en) begin
				flags.g   <= over_limit;
				// negative difference, T needs denormalizing
				flags.wdt <= sum[sign_bit];
				// result stays in T
				flags.wt  <= over_limit & ~sum[sign_bit];
			end
			// held low after a pulse so back-to-back checks stay one cycle
			flags.fi2 <= chk_en & (d > 10'sd127) & ~flags.fi2;
			flags.fi1 <= chk_en & (d < -10'sd128) & ~flags.fi1;
		end
	end

	// counter control
	always_comb begin
		cnt_clear = ctrl.align & flags.g;
		cnt_load  = align_en | prep_en;
		cnt_step  = ctrl.step;
		cnt_up    = flags.wdt;
		if (align_en) begin
			cnt_value = sum[`FPM_FIC_WIDTH-1:0];
		end else if (ops.mf) begin
			cnt_value = `FPM_FIC_WIDTH'(`FPM_FIC_MF);
		end else if (ops.df) begin
			cnt_value = `FPM_FIC_WIDTH'(`FPM_FIC_DF);
		end else if (ops.mw) begin
			cnt_value = `FPM_FIC_WIDTH'(`FPM_FIC_MW);
		end else begin
			cnt_value = `FPM_FIC_WIDTH'(`FPM_FIC_DW);
		end
	end

endmodule

// File: rtl/fpm_exp_unit.sv
/*
	FPM exponent and sequencing unit
	connects the instruction decoder, exponent adder, alignment
	indicators and shift-step counter
*/

`timescale 1ns/10ps

`include "fpm_config.svh"

module fpm_exp_unit (
	input  logic                      wdtwtg_clk,
	input  logic                      _0_f,
	input  fpm_pkg::fpm_ctrl_t        ctrl,
	input  logic [`FPM_EXP_WIDTH-1:0] w,
	input  logic                      pufa,
	input  logic                      nrf,
	output fpm_pkg::exp_t             d,
	output fpm_pkg::fp_ops_t          ops,
	output fpm_pkg::fp_class_t        op_class,
	output fpm_pkg::fpm_flags_t       flags,
	output logic                      fic
);

	import fpm_pkg::*;

	exp_t                      sum;
	logic                      over_limit;
	logic                      cnt_clear;
	logic                      cnt_load;
	logic [`FPM_FIC_WIDTH-1:0] cnt_value;
	logic                      cnt_step;
	logic                      cnt_up;

	fpm_op_decoder i_fpm_op_decoder (
		.opcode   (ctrl.opcode),
		.pufa     (pufa),
		.nrf      (nrf),
		.ops      (ops),
		.op_class (op_class)
	);

	fpm_exp_adder i_fpm_exp_adder (
		.wdtwtg_clk (wdtwtg_clk),
		._0_f       (_0_f),
		.ctrl       (ctrl),
		.w          (w),
		.d          (d),
		.sum        (sum),
		.over_limit (over_limit)
	);

	fpm_indicators i_fpm_indicators (
		.wdtwtg_clk (wdtwtg_clk),
		._0_f       (_0_f),
		.ctrl       (ctrl),
		.ops        (ops),
		.op_class   (op_class),
		.d          (d),
		.sum        (sum),
		.over_limit (over_limit),
		.flags      (flags),
		.cnt_clear  (cnt_clear),
		.cnt_load   (cnt_load),
		.cnt_value  (cnt_value),
		.cnt_step   (cnt_step),
		.cnt_up     (cnt_up)
	);

	// fic is high while the step counter sits at zero
	fpm_step_counter #(
		.width (`FPM_FIC_WIDTH)
	) i_fpm_step_counter (
		.wdtwtg_clk (wdtwtg_clk),
		._0_f       (_0_f),
		.clear      (cnt_clear),
		.load       (cnt_load),
		.load_value (cnt_value),
		.step       (cnt_step),
		.up         (cnt_up),
		.zero       (fic)
	);

endmodule

// File: testbench/fpm_exp_unit_assertions.sv
/*
	FPM exponent unit assertions
	interrupt pulse shape, decoder one-hot and prep/fic checks,
	bound to the top level
*/

`timescale 1ns/10ps

module fpm_exp_unit_assertions (
	input logic                wdtwtg_clk,
	input logic                _0_f,
	input fpm_pkg::fpm_ctrl_t  ctrl,
	input logic                pufa,
	input fpm_pkg::fp_ops_t    ops,
	input fpm_pkg::fpm_flags_t flags,
	input logic                fic
);

	import fpm_pkg::*;

	logic prep_idle;

	// prep with nothing to load, and nothing else touching the counter
	always_comb begin
		prep_idle = ctrl.prep & ~(ops.mf | ops.df | ops.mw | ops.dw) & ~ctrl.align & ~ctrl.step;
	end

	fi_exclusive: assert property (@(posedge wdtwtg_clk) disable iff (_0_f)
		!(flags.fi1 && flags.fi2))
		else $error("fi1 and fi2 are high together");

	fi1_single: assert property (@(posedge wdtwtg_clk) disable iff (_0_f)
		flags.fi1 |=> !flags.fi1)
		else $error("fi1 lasts longer than one cycle");

	fi2_single: assert property (@(posedge wdtwtg_clk) disable iff (_0_f)
		flags.fi2 |=> !flags.fi2)
		else $error("fi2 lasts longer than one cycle");

	ops_onehot: assert property (@(posedge wdtwtg_clk) disable iff (_0_f)
		pufa |-> $onehot(ops))
		else $error("ops is not one-hot with pufa high");

	ops_idle: assert property (@(posedge wdtwtg_clk) disable iff (_0_f)
		!pufa |-> (ops == '0))
		else $error("ops is not zero with pufa low");

	prep_keeps_fic: assert property (@(posedge wdtwtg_clk) disable iff (_0_f)
		(prep_idle && !fic) |=> !fic)
		else $error("fic rose after a prep with no operation selected");

endmodule

bind fpm_exp_unit fpm_exp_unit_assertions i_fpm_exp_unit_assertions (
	.wdtwtg_clk (wdtwtg_clk),
	._0_f       (_0_f),
	.ctrl       (ctrl),
	.pufa       (pufa),
	.ops        (ops),
	.flags      (flags),
	.fic        (fic)
);

// File: testbench/fpm_exp_unit_tb.sv
/*
	FPM exponent unit testbench
	directed tests for decode, W path, exponent checks, adder modes,
	alignment indicators, step counts and counter clear
*/

`timescale 1ns/10ps

`include "fpm_config.svh"

module fpm_exp_unit_tb;

	import fpm_pkg::*;

	localparam int clk_period    = 40;
	localparam int reset_cycles  = 5;
	localparam int adder_rounds  = 6;
	localparam int align_randoms = 6;
	// cycle budget of each test
	localparam int decode_cycles = 2 * 2 * 8 + 2;
	localparam int exp_cycles    = 8 + 8 * 7;
	localparam int adder_cycles  = adder_rounds * (2 + 16 + 3);
	localparam int align_cycles  = (5 + align_randoms) * 4;
	localparam int step_cycles   = 4 + 4 * (1 + 41) + 4 + 64;
	localparam int clear_cycles  = 8;
	localparam int margin_cycles = 100;
	localparam int run_cycles    = reset_cycles + decode_cycles + exp_cycles + adder_cycles
		+ align_cycles + step_cycles + clear_cycles + margin_cycles;
	localparam int cnt_range     = 1 << `FPM_FIC_WIDTH;

	logic       wdtwtg_clk;
	logic       _0_f;
	fpm_ctrl_t  ctrl;
	logic [7:0] w;
	logic       pufa;
	logic       nrf;
	exp_t       d;
	fp_ops_t    ops;
	fp_class_t  op_class;
	fpm_flags_t flags;
	logic       fic;

	int          error_count;
	int          check_count;
	logic [31:0] rng_state;
	// indicator state the testbench expects
	logic        model_g;

	fpm_exp_unit i_fpm_exp_unit (
		.wdtwtg_clk (wdtwtg_clk),
		._0_f       (_0_f),
		.ctrl       (ctrl),
		.w          (w),
		.pufa       (pufa),
		.nrf        (nrf),
		.d          (d),
		.ops        (ops),
		.op_class   (op_class),
		.flags      (flags),
		.fic        (fic)
	);

	initial begin
		wdtwtg_clk = 1'b0;
		forever begin
			#(clk_period / 2) wdtwtg_clk = ~wdtwtg_clk;
		end
	end

	function automatic logic [31:0] next_random();
		logic [31:0] s;
		s = rng_state;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		rng_state = s;
		return s;
	endfunction

	function automatic int signed_byte(input logic [7:0] v);
		return (v >= 8'd128) ? int'(v) - 256 : int'(v);
	endfunction

	// value of the ten-bit D register after wrapping
	function automatic int wrap10(input int v);
		int r;
		r = v % 1024;
		if (r < 0) r = r + 1024;
		if (r >= 512) r = r - 1024;
		return r;
	endfunction

	// signed value of the B bus where ~b equals -b-1
	function automatic int bus_value(input logic [7:0] b, input logic [1:0] mode);
		case (mode)
			2'b00: return -signed_byte(b) - 1;
			2'b01: return signed_byte(b);
			2'b10: return -1;
			default: return 0;
		endcase
	endfunction

	function automatic int counter_bits(input int v);
		int r;
		r = v % cnt_range;
		if (r < 0) r = r + cnt_range;
		return r;
	endfunction

	function automatic fpm_ctrl_t quiet_ctrl(input fp_opcode_t op);
		fpm_ctrl_t c;
		c = '0;
		c.opcode = op;
		return c;
	endfunction

	task automatic check_value(input string test_name, input string what,
			input int expected, input int actual);
		check_count++;
		assert (expected == actual) else begin
			error_count++;
			$display("FAIL %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
		end
	endtask

	// one-cycle strobe that starts and ends on a falling edge
	task automatic strobe(input fpm_ctrl_t c);
		ctrl = c;
		@(negedge wdtwtg_clk);
		ctrl = quiet_ctrl(c.opcode);
	endtask

	task automatic load_w(input logic [7:0] val, input fp_opcode_t op);
		fpm_ctrl_t c;
		c = quiet_ctrl(op);
		c.ld_d = 1'b1;
		c.lkb = 1'b1;
		w = val;
		strobe(c);
	endtask

	task automatic load_b(input fp_opcode_t op);
		fpm_ctrl_t c;
		c = quiet_ctrl(op);
		c.ld_b = 1'b1;
		strobe(c);
	endtask

	task automatic add_loopback(input logic [1:0] mode, input logic carry, input fp_opcode_t op);
		fpm_ctrl_t c;
		c = quiet_ctrl(op);
		c.ld_d = 1'b1;
		c.fcb = mode[1];
		c.scc = mode[0];
		c.pc8 = carry;
		strobe(c);
	endtask

	// D = 2 * W through B and the true mode
	task automatic double_w(input logic [7:0] val, input fp_opcode_t op, input string test_name);
		load_w(val, op);
		load_b(op);
		add_loopback(2'b01, 1'b0, op);
		check_value(test_name, "d", wrap10(2 * signed_byte(val)), int'(d));
	endtask

	task automatic exp_check_pulse(input fp_opcode_t op, input logic fi1_exp,
			input logic fi2_exp, input string test_name);
		fpm_ctrl_t c;
		c = quiet_ctrl(op);
		c.exp_chk = 1'b1;
		strobe(c);
		check_value(test_name, "fi1", int'(fi1_exp), int'(flags.fi1));
		check_value(test_name, "fi2", int'(fi2_exp), int'(flags.fi2));
		@(negedge wdtwtg_clk);
		check_value(test_name, "fi1 next cycle", 0, int'(flags.fi1));
		check_value(test_name, "fi2 next cycle", 0, int'(flags.fi2));
	endtask

	// two exp_chk strobes in a row still give a single-cycle pulse
	task automatic exp_check_twice(input fp_opcode_t op, input logic fi1_exp,
			input logic fi2_exp, input string test_name);
		fpm_ctrl_t c;
		c = quiet_ctrl(op);
		c.exp_chk = 1'b1;
		strobe(c);
		check_value(test_name, "fi1", int'(fi1_exp), int'(flags.fi1));
		check_value(test_name, "fi2", int'(fi2_exp), int'(flags.fi2));
		strobe(c);
		check_value(test_name, "fi1 second strobe", 0, int'(flags.fi1));
		check_value(test_name, "fi2 second strobe", 0, int'(flags.fi2));
	endtask

	// load D with e1 and B with e2 then align on their difference
	task automatic align_pair(input int e1, input int e2, input fp_opcode_t op,
			input string test_name);
		fpm_ctrl_t c;
		int        diff;
		logic      over;
		logic      fic_exp;
		diff = e1 - e2;
		over = (diff >= `FPM_ALIGN_LIMIT) || (diff <= -`FPM_ALIGN_LIMIT);
		load_w(8'(e2), op);
		load_b(op);
		load_w(8'(e1), op);
		c = quiet_ctrl(op);
		c.pc8 = 1'b1;
		c.align = 1'b1;
		// g already set means the counter is cleared instead
		fic_exp = model_g ? 1'b1 : (counter_bits(diff) == 0);
		strobe(c);
		model_g = over;
		check_value(test_name, "g", int'(over), int'(flags.g));
		check_value(test_name, "wdt", int'(diff < 0), int'(flags.wdt));
		check_value(test_name, "wt", int'(over && diff >= 0), int'(flags.wt));
		check_value(test_name, "fic", int'(fic_exp), int'(fic));
	endtask

	task automatic reset_and_decode();
		int exp_ops;
		int exp_class;
		check_value("reset", "flags", 0, int'(flags));
		check_value("reset", "fic", 1, int'(fic));
		check_value("reset", "d", 0, int'(d));
		for (int p = 0; p < 2; p++) begin
			for (int n = 0; n < 2; n++) begin
				for (int op = 0; op < 8; op++) begin
					ctrl = quiet_ctrl(3'(op));
					pufa = p[0];
					nrf = n[0];
					@(negedge wdtwtg_clk);
					exp_ops = (p == 1) ? (1 << (7 - op)) : 0;
					exp_class = (((n == 1) || (op >= 4)) ? 4 : 0)
						+ (((p == 1) && (op < 4)) ? 2 : 0) + (((p == 1) || (n == 1)) ? 1 : 0);
					check_value("decode", "ops", exp_ops, int'(ops));
					check_value("decode", "op_class", exp_class, int'(op_class));
				end
			end
		end
		pufa = 1'b1;
		nrf = 1'b0;
	endtask

	task automatic w_path_and_exp_check();
		logic [31:0] r;
		for (int i = 0; i < 8; i++) begin
			r = next_random();
			load_w(r[7:0], 3'd0);
			check_value("w_path", "d", signed_byte(r[7:0]), int'(d));
		end
		double_w(8'd65, 3'd4, "exp_check");
		exp_check_pulse(3'd4, 1'b0, 1'b1, "exp_check 130 af");
		exp_check_pulse(3'd0, 1'b0, 1'b0, "exp_check 130 ad");
		exp_check_twice(3'd4, 1'b0, 1'b1, "exp_check 130 af twice");
		double_w(8'd64, 3'd6, "exp_check");
		exp_check_pulse(3'd6, 1'b0, 1'b1, "exp_check 128 mf");
		load_w(8'd127, 3'd4);
		exp_check_pulse(3'd4, 1'b0, 1'b0, "exp_check 127 af");
		double_w(8'hbf, 3'd5, "exp_check");
		exp_check_pulse(3'd5, 1'b1, 1'b0, "exp_check -130 sf");
		exp_check_pulse(3'd1, 1'b0, 1'b0, "exp_check -130 sd");
		exp_check_twice(3'd5, 1'b1, 1'b0, "exp_check -130 sf twice");
		load_w(8'h80, 3'd7);
		exp_check_pulse(3'd7, 1'b0, 1'b0, "exp_check -128 df");
		add_loopback(2'b10, 1'b0, 3'd7);
		check_value("exp_check", "d", -129, int'(d));
		exp_check_pulse(3'd7, 1'b1, 1'b0, "exp_check -129 df");
	endtask

	task automatic adder_modes();
		logic [31:0] r;
		logic [7:0]  b_val;
		logic [7:0]  d_val;
		int          expected;
		for (int round = 0; round < adder_rounds; round++) begin
			r = next_random();
			b_val = r[7:0];
			d_val = r[15:8];
			load_w(b_val, 3'd0);
			load_b(3'd0);
			for (int mode = 0; mode < 4; mode++) begin
				for (int carry = 0; carry < 2; carry++) begin
					load_w(d_val, 3'd0);
					add_loopback(2'(mode), carry[0], 3'd0);
					expected = wrap10(signed_byte(d_val) + bus_value(b_val, 2'(mode)) + carry);
					check_value("adder_modes", "d", expected, int'(d));
				end
			end
			// chained adds walk into the guard bits and wrap
			for (int k = 0; k < 3; k++) begin
				add_loopback(2'b01, 1'b1, 3'd0);
				expected = wrap10(expected + signed_byte(b_val) + 1);
				check_value("adder_modes chain", "d", expected, int'(d));
			end
		end
	endtask

	task automatic alignment_indicators();
		logic [31:0] r;
		align_pair(50, 11, 3'd4, "align diff 39");
		align_pair(60, 20, 3'd5, "align diff 40");
		align_pair(20, 60, 3'd4, "align diff -40");
		align_pair(33, 33, 3'd5, "align diff 0");
		align_pair(-100, 27, 3'd4, "align diff -127");
		for (int i = 0; i < align_randoms; i++) begin
			r = next_random();
			align_pair(signed_byte(r[7:0]), signed_byte(r[15:8]), 3'(4 + i % 2), "align random");
		end
	endtask

	task automatic step_counts();
		fpm_ctrl_t c;
		fp_opcode_t op_list[4];
		int         count_list[4];
		logic [31:0] r;
		int          diff;
		int          steps;
		op_list = '{3'd6, 3'd7, 3'd2, 3'd3};
		count_list = '{`FPM_FIC_MF, `FPM_FIC_DF, `FPM_FIC_MW, `FPM_FIC_DW};
		// zero difference leaves wdt low for counting down
		align_pair(10, 10, 3'd4, "step_counts setup");
		for (int i = 0; i < 4; i++) begin
			c = quiet_ctrl(op_list[i]);
			c.prep = 1'b1;
			strobe(c);
			check_value("step_counts prep", "fic", 0, int'(fic));
			c = quiet_ctrl(op_list[i]);
			c.step = 1'b1;
			for (int k = 1; k <= count_list[i]; k++) begin
				strobe(c);
				check_value("step_counts down", "fic", int'(k == count_list[i]), int'(fic));
			end
		end
		r = next_random();
		diff = -(1 + int'(r[7:0]) % (`FPM_ALIGN_LIMIT - 1));
		align_pair(20, 20 - diff, 3'd4, "step_counts negative");
		// prep under af loads nothing so the count is kept
		c = quiet_ctrl(3'd4);
		c.prep = 1'b1;
		strobe(c);
		check_value("step_counts idle prep", "fic", 0, int'(fic));
		steps = cnt_range - counter_bits(diff);
		c = quiet_ctrl(3'd4);
		c.step = 1'b1;
		for (int k = 1; k <= steps; k++) begin
			strobe(c);
			check_value("step_counts up", "fic", int'(k == steps), int'(fic));
		end
	endtask

	task automatic counter_clear();
		align_pair(70, 10, 3'd5, "counter_clear set g");
		align_pair(15, 10, 3'd5, "counter_clear second align");
	endtask

	// watchdog
	initial begin
		repeat (run_cycles) @(posedge wdtwtg_clk);
		$display("timeout: tests did not finish within %0d cycles", run_cycles);
		$display("Simulation failed");
		$finish;
	end

	initial begin
		error_count = 0;
		check_count = 0;
		rng_state = 32'h0427_39f2;
		model_g = 1'b0;
		ctrl = '0;
		w = '0;
		pufa = 1'b0;
		nrf = 1'b0;
		_0_f = 1'b1;
		repeat (reset_cycles) @(negedge wdtwtg_clk);
		_0_f = 1'b0;
		@(negedge wdtwtg_clk);
		reset_and_decode();
		w_path_and_exp_check();
		adder_modes();
		alignment_indicators();
		step_counts();
		counter_clear();
		$display("errors: %0d of %0d checks", error_count, check_count);
		if (error_count == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// File: fpm_exp_unit.f
+incdir+include
rtl/fpm_pkg.sv
rtl/fpm_op_decoder.sv
rtl/fpm_exp_adder.sv
rtl/fpm_step_counter.sv
rtl/fpm_indicators.sv
rtl/fpm_exp_unit.sv
testbench/fpm_exp_unit_assertions.sv
testbench/fpm_exp_unit_tb.sv

// File: Makefile
# Verilator build for the FPM exponent unit

VERILATOR ?= verilator
TOP       := fpm_exp_unit_tb
FILELIST  := fpm_exp_unit.f
OBJDIR    := obj_dir
LOG       := sim.log
PASS_MSG  := Simulation passed
LINTFLAGS := --lint-only --timing --assert
VFLAGS    := --binary --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "no pass message in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)
